//--- testbench/dual_issue_vectors.txt
// per slot: en op rd rj rk imm, slot 0 then slot 1, all hex
// op: 0 nop 1 add 2 sub 3 and 4 or 5 xor 6 sll 7 srl 8 slt 9 addi a lui, f in column 1 ends
1 a 01 00 00 00012345  1 9 02 00 00 00000678
1 9 03 00 00 fffffffb  1 9 04 00 00 00000007
1 1 05 01 02 00000000  1 2 06 04 03 00000000
1 3 07 05 01 00000000  1 4 08 05 02 00000000
1 5 09 05 03 00000000  1 6 0a 04 03 00000000
1 7 0b 03 04 00000000  1 8 0c 03 04 00000000
1 8 0d 04 03 00000000  1 6 0e 01 02 00000000
// in-pair dependency, then a chain across pairs
1 9 0f 04 00 0000000a  1 1 10 0f 0f 00000000
1 1 11 10 0f 00000000  1 1 12 11 11 00000000
1 1 13 12 11 00000000  1 9 14 13 00 00000001
1 2 15 14 13 00000000  1 5 16 15 14 00000000
1 9 15 15 00 00000003  0 0 00 00 00 00000000
1 9 15 15 00 00000003  1 9 15 15 00 00000003
// writes to r0, then reads of r0
1 9 00 04 00 00000063  1 1 17 00 04 00000000
1 a 00 00 00 000fffff  1 4 18 00 00 00000000
// waw inside a pair and across pairs
1 9 19 00 00 00000111  1 9 19 00 00 00000222
1 9 1a 00 00 00000aaa  1 0 00 00 00 00000000
1 9 1a 00 00 00000bbb  0 0 00 00 00 00000000
1 1 1b 19 1a 00000000  1 2 1c 1a 19 00000000
1 0 05 05 05 00000000  0 0 00 00 00 00000000
0 0 00 00 00 00000000  0 0 00 00 00 00000000
1 6 1d 05 0b 00000000  1 7 1e 05 0b 00000000
1 8 1f 0c 0d 00000000  1 8 01 03 03 00000000
1 1 02 1f 01 00000000  1 3 03 1e 1d 00000000
1 1 04 03 02 00000000  1 9 03 00 00 00000055
1 5 05 04 03 00000000  1 2 06 00 05 00000000
1 8 07 06 00 00000000  1 7 08 06 04 00000000
1 6 09 06 04 00000000  1 2 0a 0d 0c 00000000
f 0 00 00 00 00000000  0 0 00 00 00 00000000

//--- dual_issue_core.f
src/dual_issue_pkg.sv
src/alu_lane.sv
src/register_file.sv
src/issue_stage.sv
src/writeback.sv
src/dual_issue_core.sv
testbench/tb_dual_issue_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_dual_issue_core \
    -f dual_issue_core.f \
    -o sim_dual_issue_core \
    && ./obj_dir/sim_dual_issue_core \
    || { echo "simulation did not pass" >&2; exit 1; }

//--- testbench/tb_dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dual_issue_core;
    import dual_issue_pkg::*;

    localparam int NUM_LANES   = 2;
    localparam int SLOT_FIELDS = 6;
    localparam int FIELDS      = NUM_LANES * SLOT_FIELDS;
    localparam int MAX_VECS    = 64;
    localparam logic [31:0] END_MARK = 32'h0000000f;

    logic                      aclk;
    logic                      aresetn;
    logic                      i_in_valid;
    logic [NUM_LANES-1:0]      i_slot_en;
    opcode_e   [NUM_LANES-1:0] i_slot_op;
    reg_addr_t [NUM_LANES-1:0] i_slot_rd;
    reg_addr_t [NUM_LANES-1:0] i_slot_rj;
    reg_addr_t [NUM_LANES-1:0] i_slot_rk;
    word_t     [NUM_LANES-1:0] i_slot_imm;
    logic                      o_in_ready;
    logic [NUM_LANES-1:0]      o_wb_valid;
    reg_addr_t [NUM_LANES-1:0] o_wb_rd;
    word_t     [NUM_LANES-1:0] o_wb_data;

    logic [31:0] vec_mem [MAX_VECS*FIELDS];
    word_t       model_regs [NUM_REGS];
    reg_addr_t   exp_rd [$];
    word_t       exp_data [$];
    int          vec_count;
    int          cycle_count;
    int          cycle_limit;
    int          ready_low_cycles;
    int unsigned lcg_state;

    dual_issue_core #(
        .NUM_LANES (NUM_LANES)
    ) dut0 (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .i_in_valid (i_in_valid),
        .i_slot_en  (i_slot_en),
        .i_slot_op  (i_slot_op),
        .i_slot_rd  (i_slot_rd),
        .i_slot_rj  (i_slot_rj),
        .i_slot_rk  (i_slot_rk),
        .i_slot_imm (i_slot_imm),
        .o_in_ready (o_in_ready),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data)
    );

    always #10 aclk = ~aclk;

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_rd(input reg_addr_t got, input reg_addr_t expected, input int lane);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: lane %0d wrote r%0d, expected r%0d",
                     $time, lane, got, expected);
            report_failure();
        end
    endtask

    task automatic check_data(input word_t got, input word_t expected, input int lane);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: lane %0d data %08h, expected %08h",
                     $time, lane, got, expected);
            report_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s is %0b, expected %0b", $time, what, got, expected);
            report_failure();
        end
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // reference semantics of each opcode
    function automatic word_t golden_result(opcode_e op, word_t j, word_t k, word_t imm);
        word_t r;
        case (op)
            OP_ADD:  r = j + k;
            OP_SUB:  r = j - k;
            OP_AND:  r = j & k;
            OP_OR:   r = j | k;
            OP_XOR:  r = j ^ k;
            OP_SLL:  r = j << k[4:0];
            OP_SRL:  r = j >> k[4:0];
            OP_SLT:  r = ($signed(j) < $signed(k)) ? 32'd1 : 32'd0;
            OP_ADDI: r = j + imm;
            OP_LUI:  r = {imm[XLEN-13:0], 12'h000};
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic drive_pair(input int v);
        int base;
        for (int s = 0; s < NUM_LANES; s++) begin
            base = v * FIELDS + s * SLOT_FIELDS;
            i_slot_en[s]  = vec_mem[base][0];
            i_slot_op[s]  = opcode_e'(vec_mem[base+1][3:0]);
            i_slot_rd[s]  = vec_mem[base+2][REG_ADDR_W-1:0];
            i_slot_rj[s]  = vec_mem[base+3][REG_ADDR_W-1:0];
            i_slot_rk[s]  = vec_mem[base+4][REG_ADDR_W-1:0];
            i_slot_imm[s] = vec_mem[base+5];
        end
        i_in_valid = 1'b1;
    endtask

    // program order, so slot 1 sees what slot 0 just wrote
    task automatic apply_to_model(input int v);
        int        base;
        opcode_e   op;
        reg_addr_t rd;
        word_t     value;
        for (int s = 0; s < NUM_LANES; s++) begin
            base = v * FIELDS + s * SLOT_FIELDS;
            if (vec_mem[base][0]) begin
                op    = opcode_e'(vec_mem[base+1][3:0]);
                rd    = vec_mem[base+2][REG_ADDR_W-1:0];
                value = golden_result(op, model_regs[vec_mem[base+3][REG_ADDR_W-1:0]],
                                      model_regs[vec_mem[base+4][REG_ADDR_W-1:0]],
                                      vec_mem[base+5]);
                if (op != OP_NOP && rd != '0) begin
                    model_regs[rd] = value;
                    exp_rd.push_back(rd);
                    exp_data.push_back(value);
                end
            end
        end
    endtask

    // trace entries against expected writes, lane 0 is older
    always @(negedge aclk) begin
        if (aresetn) begin
            if (!o_in_ready) ready_low_cycles++;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (o_wb_valid[l]) begin
                    if (exp_rd.size() == 0) begin
                        $display("lane %0d retired r%0d at %0t ns but no write was expected",
                                 l, o_wb_rd[l], $time);
                        report_failure();
                    end else begin
                        check_rd(o_wb_rd[l], exp_rd.pop_front(), l);
                        check_data(o_wb_data[l], exp_data.pop_front(), l);
                    end
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: no finish within %0d cycles, %0d writes still expected",
                     cycle_limit, exp_rd.size());
            report_failure();
        end
    end

    initial begin
        int gap;
        aclk             = 1'b0;
        aresetn          = 1'b0;
        i_in_valid       = 1'b0;
        i_slot_en        = '0;
        for (int s = 0; s < NUM_LANES; s++) begin
            i_slot_op[s]  = OP_NOP;
            i_slot_rd[s]  = '0;
            i_slot_rj[s]  = '0;
            i_slot_rk[s]  = '0;
            i_slot_imm[s] = '0;
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        cycle_count      = 0;
        ready_low_cycles = 0;
        lcg_state        = 24665;

        $readmemh("testbench/dual_issue_vectors.txt", vec_mem);
        vec_count = 0;
        while (vec_count < MAX_VECS && vec_mem[vec_count*FIELDS] != END_MARK) begin
            vec_count++;
        end
        cycle_limit = vec_count * 8 + 50;
        if (vec_count == 0) begin
            $display("the vector file holds no input pairs");
            report_failure();
        end

        repeat (2) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        check_flag(|o_wb_valid, 1'b0, "o_wb_valid after reset");
        check_flag(o_in_ready, 1'b1, "o_in_ready after reset");

        for (int v = 0; v < vec_count; v++) begin
            gap = int'((lcg_next() >> 16) % 4);
            repeat (gap) @(negedge aclk);
            drive_pair(v);
            // ready is settled here, the pair goes at the next rising edge
            while (!o_in_ready) @(negedge aclk);
            apply_to_model(v);
            @(negedge aclk);
            i_in_valid = 1'b0;
        end

        while (exp_rd.size() != 0) @(negedge aclk);
        // one more pipeline depth to catch stray trace entries
        repeat (4) @(negedge aclk);
        check_flag(ready_low_cycles != 0, 1'b1, "o_in_ready seen low during dependencies");
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/dual_issue_core.sv
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core #(
    parameter int NUM_LANES = 2
) (
    input  wire                                             aclk,
    input  wire                                             aresetn,
    input  wire                                             i_in_valid,
    input  wire  [NUM_LANES-1:0]                            i_slot_en,
    input  wire  dual_issue_pkg::opcode_e   [NUM_LANES-1:0] i_slot_op,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rd,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rj,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rk,
    input  wire  dual_issue_pkg::word_t     [NUM_LANES-1:0] i_slot_imm,
    output logic                                            o_in_ready,
    output logic [NUM_LANES-1:0]                            o_wb_valid,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_wb_rd,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_wb_data
);
    import dual_issue_pkg::*;

    wire [NUM_LANES-1:0]            issue_valid;
    wire opcode_e   [NUM_LANES-1:0] issue_op;
    wire reg_addr_t [NUM_LANES-1:0] issue_rd;
    wire reg_addr_t [NUM_LANES-1:0] issue_rj;
    wire reg_addr_t [NUM_LANES-1:0] issue_rk;
    wire word_t     [NUM_LANES-1:0] issue_imm;

    wire [NUM_LANES-1:0]            rd_valid;
    wire opcode_e   [NUM_LANES-1:0] rd_op;
    wire reg_addr_t [NUM_LANES-1:0] rd_dst;
    wire word_t     [NUM_LANES-1:0] operand_j;
    wire word_t     [NUM_LANES-1:0] operand_k;
    wire word_t     [NUM_LANES-1:0] rd_imm;

    wire [NUM_LANES-1:0]            ex_valid;
    wire reg_addr_t [NUM_LANES-1:0] ex_rd;
    wire word_t     [NUM_LANES-1:0] ex_data;

    wire [NUM_LANES-1:0]            wr_en;
    wire reg_addr_t [NUM_LANES-1:0] wr_addr;
    wire word_t     [NUM_LANES-1:0] wr_data;
    wire [NUM_LANES-1:0]            release_en;
    wire reg_addr_t [NUM_LANES-1:0] release_addr;

    issue_stage #(
        .NUM_LANES (NUM_LANES)
    ) u_issue (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_in_valid     (i_in_valid),
        .i_slot_en      (i_slot_en),
        .i_slot_op      (i_slot_op),
        .i_slot_rd      (i_slot_rd),
        .i_slot_rj      (i_slot_rj),
        .i_slot_rk      (i_slot_rk),
        .i_slot_imm     (i_slot_imm),
        .i_release_en   (release_en),
        .i_release_addr (release_addr),
        .o_in_ready     (o_in_ready),
        .o_issue_valid  (issue_valid),
        .o_issue_op     (issue_op),
        .o_issue_rd     (issue_rd),
        .o_issue_rj     (issue_rj),
        .o_issue_rk     (issue_rk),
        .o_issue_imm    (issue_imm)
    );

    register_file #(
        .NUM_LANES (NUM_LANES)
    ) u_regfile (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .i_issue_valid (issue_valid),
        .i_issue_op    (issue_op),
        .i_issue_rd    (issue_rd),
        .i_issue_rj    (issue_rj),
        .i_issue_rk    (issue_rk),
        .i_issue_imm   (issue_imm),
        .i_wr_en       (wr_en),
        .i_wr_addr     (wr_addr),
        .i_wr_data     (wr_data),
        .o_rd_valid    (rd_valid),
        .o_rd_op       (rd_op),
        .o_rd_dst      (rd_dst),
        .o_operand_j   (operand_j),
        .o_operand_k   (operand_k),
        .o_rd_imm      (rd_imm)
    );

    // one lane per issue slot
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        alu_lane u_lane (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_valid     (rd_valid[l]),
            .i_op        (rd_op[l]),
            .i_dst       (rd_dst[l]),
            .i_operand_j (operand_j[l]),
            .i_operand_k (operand_k[l]),
            .i_imm       (rd_imm[l]),
            .o_valid     (ex_valid[l]),
            .o_rd        (ex_rd[l]),
            .o_data      (ex_data[l])
        );
    end

    writeback #(
        .NUM_LANES (NUM_LANES)
    ) u_writeback (
        .i_ex_valid     (ex_valid),
        .i_ex_rd        (ex_rd),
        .i_ex_data      (ex_data),
        .o_wr_en        (wr_en),
        .o_wr_addr      (wr_addr),
        .o_wr_data      (wr_data),
        .o_release_en   (release_en),
        .o_release_addr (release_addr),
        .o_wb_valid     (o_wb_valid),
        .o_wb_rd        (o_wb_rd),
        .o_wb_data      (o_wb_data)
    );

endmodule

`default_nettype wire

//--- src/writeback.sv
`timescale 1ns/1ps
`default_nettype none

module writeback #(
    parameter int NUM_LANES = 2
) (
    input  wire  [NUM_LANES-1:0]                            i_ex_valid,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_ex_rd,
    input  wire  dual_issue_pkg::word_t     [NUM_LANES-1:0] i_ex_data,
    output logic [NUM_LANES-1:0]                            o_wr_en,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_wr_addr,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_wr_data,
    output logic [NUM_LANES-1:0]                            o_release_en,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_release_addr,
    output logic [NUM_LANES-1:0]                            o_wb_valid,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_wb_rd,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_wb_data
);
    import dual_issue_pkg::*;

    logic [NUM_LANES-1:0] keep;

    // results aimed at r0 are dropped here, never written or traced
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            keep[l]           = i_ex_valid[l] && (i_ex_rd[l] != '0);
            o_wr_en[l]        = keep[l];
            o_wr_addr[l]      = i_ex_rd[l];
            o_wr_data[l]      = i_ex_data[l];
            o_release_en[l]   = keep[l];
            o_release_addr[l] = i_ex_rd[l];
            o_wb_valid[l]     = keep[l];
            o_wb_rd[l]        = i_ex_rd[l];
            o_wb_data[l]      = i_ex_data[l];
        end
    end

endmodule

`default_nettype wire

//--- src/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
    parameter int NUM_LANES = 2
) (
    input  wire                                             aclk,
    input  wire                                             aresetn,
    input  wire                                             i_in_valid,
    input  wire  [NUM_LANES-1:0]                            i_slot_en,
    input  wire  dual_issue_pkg::opcode_e   [NUM_LANES-1:0] i_slot_op,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rd,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rj,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_slot_rk,
    input  wire  dual_issue_pkg::word_t     [NUM_LANES-1:0] i_slot_imm,
    input  wire  [NUM_LANES-1:0]                            i_release_en,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_release_addr,
    output logic                                            o_in_ready,
    output logic [NUM_LANES-1:0]                            o_issue_valid,
    output dual_issue_pkg::opcode_e         [NUM_LANES-1:0] o_issue_op,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_issue_rd,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_issue_rj,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_issue_rk,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_issue_imm
);
    import dual_issue_pkg::*;

    issue_state_e              state;
    logic [NUM_LANES-1:0]      pend;
    opcode_e   [NUM_LANES-1:0] held_op;
    reg_addr_t [NUM_LANES-1:0] held_rd;
    reg_addr_t [NUM_LANES-1:0] held_rj;
    reg_addr_t [NUM_LANES-1:0] held_rk;
    word_t     [NUM_LANES-1:0] held_imm;
    logic [NUM_REGS-1:0]       busy;
    logic [NUM_REGS-1:0]       set_mask;
    logic [NUM_REGS-1:0]       clr_mask;
    logic [NUM_LANES-1:0]      uses_j;
    logic [NUM_LANES-1:0]      uses_k;
    logic [NUM_LANES-1:0]      writes;
    logic [NUM_LANES-1:0]      go;
    logic                      accept;

    function automatic logic reads_j(opcode_e op);
        return !(op inside {OP_NOP, OP_LUI});
    endfunction

    function automatic logic reads_k(opcode_e op);
        return !(op inside {OP_NOP, OP_LUI, OP_ADDI});
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            uses_j[i] = reads_j(held_op[i]);
            uses_k[i] = reads_k(held_op[i]);
            writes[i] = (held_op[i] != OP_NOP) && (held_rd[i] != '0);
        end
    end

    // longest ready prefix of the slots still waiting
    always_comb begin
        logic ok;
        go = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            ok = pend[i];
            if (uses_j[i] && busy[held_rj[i]]) ok = 1'b0;
            if (uses_k[i] && busy[held_rk[i]]) ok = 1'b0;
            if (writes[i] && busy[held_rd[i]]) ok = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (pend[j] && !go[j]) ok = 1'b0;
                // raw or waw against an older slot going in the same cycle
                if (go[j] && writes[j]) begin
                    if (uses_j[i] && held_rj[i] == held_rd[j]) ok = 1'b0;
                    if (uses_k[i] && held_rk[i] == held_rd[j]) ok = 1'b0;
                    if (writes[i] && held_rd[i] == held_rd[j]) ok = 1'b0;
                end
            end
            go[i] = ok;
        end
    end

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (go[i] && writes[i]) set_mask[held_rd[i]] = 1'b1;
            if (i_release_en[i]) clr_mask[i_release_addr[i]] = 1'b1;
        end
    end

    assign o_in_ready = (state == ISSUE_EMPTY) || ((pend & ~go) == '0);
    assign accept     = i_in_valid && o_in_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state         <= ISSUE_EMPTY;
            pend          <= '0;
            busy          <= '0;
            o_issue_valid <= '0;
        end else begin
            busy          <= (busy & ~clr_mask) | set_mask;
            o_issue_valid <= go;
            if (accept) begin
                pend  <= i_slot_en;
                state <= (i_slot_en == '0) ? ISSUE_EMPTY : ISSUE_PAIR;
            end else begin
                pend <= pend & ~go;
                case (state)
                    ISSUE_PAIR, ISSUE_SECOND: begin
                        if ((pend & ~go) == '0) begin
                            state <= ISSUE_EMPTY;
                        end else if (go != '0) begin
                            state <= ISSUE_SECOND;
                        end
                    end
                    default: state <= ISSUE_EMPTY;
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            held_op  <= i_slot_op;
            held_rd  <= i_slot_rd;
            held_rj  <= i_slot_rj;
            held_rk  <= i_slot_rk;
            held_imm <= i_slot_imm;
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (go[i]) begin
                o_issue_op[i]  <= held_op[i];
                o_issue_rd[i]  <= held_rd[i];
                o_issue_rj[i]  <= held_rj[i];
                o_issue_rk[i]  <= held_rk[i];
                o_issue_imm[i] <= held_imm[i];
            end
        end
    end

    // no source may name a writer still in the operand or lane stage
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_chk
        for (genvar m = 0; m < NUM_LANES; m++) begin : g_old
            for (genvar d = 1; d <= 2; d++) begin : g_dly
                a_no_busy_read: assert property (@(posedge aclk) disable iff (!aresetn)
                    o_issue_valid[l] && $past(o_issue_valid[m], d) &&
                    ($past(o_issue_op[m], d) != OP_NOP) &&
                    ($past(o_issue_rd[m], d) != '0)
                    |-> !(reads_j(o_issue_op[l]) &&
                          (o_issue_rj[l] == $past(o_issue_rd[m], d))) &&
                        !(reads_k(o_issue_op[l]) &&
                          (o_issue_rk[l] == $past(o_issue_rd[m], d))));
            end
        end
    end

endmodule

`default_nettype wire

//--- src/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file #(
    parameter int NUM_LANES = 2
) (
    input  wire                                             aclk,
    input  wire                                             aresetn,
    input  wire  [NUM_LANES-1:0]                            i_issue_valid,
    input  wire  dual_issue_pkg::opcode_e   [NUM_LANES-1:0] i_issue_op,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_issue_rd,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_issue_rj,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_issue_rk,
    input  wire  dual_issue_pkg::word_t     [NUM_LANES-1:0] i_issue_imm,
    input  wire  [NUM_LANES-1:0]                            i_wr_en,
    input  wire  dual_issue_pkg::reg_addr_t [NUM_LANES-1:0] i_wr_addr,
    input  wire  dual_issue_pkg::word_t     [NUM_LANES-1:0] i_wr_data,
    output logic [NUM_LANES-1:0]                            o_rd_valid,
    output dual_issue_pkg::opcode_e         [NUM_LANES-1:0] o_rd_op,
    output dual_issue_pkg::reg_addr_t       [NUM_LANES-1:0] o_rd_dst,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_operand_j,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_operand_k,
    output dual_issue_pkg::word_t           [NUM_LANES-1:0] o_rd_imm
);
    import dual_issue_pkg::*;

    word_t regs [NUM_REGS];

    // r0 is never written so it keeps its reset value of zero
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_LANES; w++) begin
                if (i_wr_en[w] && (i_wr_addr[w] != '0)) begin
                    regs[i_wr_addr[w]] <= i_wr_data[w];
                end
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_rd_valid <= '0;
        end else begin
            o_rd_valid <= i_issue_valid;
        end
    end

    // operand stage, two reads per lane
    always_ff @(posedge aclk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            o_rd_op[l]     <= i_issue_op[l];
            o_rd_dst[l]    <= i_issue_rd[l];
            o_operand_j[l] <= regs[i_issue_rj[l]];
            o_operand_k[l] <= regs[i_issue_rk[l]];
            o_rd_imm[l]    <= i_issue_imm[l];
        end
    end

    // the scoreboard keeps two writes to one register out of the same cycle
    for (genvar a = 0; a < NUM_LANES; a++) begin : g_wr_chk
        for (genvar b = a + 1; b < NUM_LANES; b++) begin : g_pair
            a_wr_unique: assert property (@(posedge aclk) disable iff (!aresetn)
                !(i_wr_en[a] && i_wr_en[b] && (i_wr_addr[a] == i_wr_addr[b])));
        end
    end

endmodule

`default_nettype wire

//--- src/alu_lane.sv
`timescale 1ns/1ps
`default_nettype none

module alu_lane (
    input  wire                        aclk,
    input  wire                        aresetn,
    input  wire                        i_valid,
    input  wire dual_issue_pkg::opcode_e   i_op,
    input  wire dual_issue_pkg::reg_addr_t i_dst,
    input  wire dual_issue_pkg::word_t     i_operand_j,
    input  wire dual_issue_pkg::word_t     i_operand_k,
    input  wire dual_issue_pkg::word_t     i_imm,
    output logic                       o_valid,
    output dual_issue_pkg::reg_addr_t  o_rd,
    output dual_issue_pkg::word_t      o_data
);
    import dual_issue_pkg::*;

    word_t      result;
    logic [4:0] shamt;
    logic       less;

    // shifts only look at the low 5 bits of rk
    assign shamt = i_operand_k[4:0];
    assign less  = $signed(i_operand_j) < $signed(i_operand_k);

    always_comb begin
        case (i_op)
            OP_ADD:  result = i_operand_j + i_operand_k;
            OP_SUB:  result = i_operand_j - i_operand_k;
            OP_AND:  result = i_operand_j & i_operand_k;
            OP_OR:   result = i_operand_j | i_operand_k;
            OP_XOR:  result = i_operand_j ^ i_operand_k;
            OP_SLL:  result = i_operand_j << shamt;
            OP_SRL:  result = i_operand_j >> shamt;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, less};
            OP_ADDI: result = i_operand_j + i_imm;
            OP_LUI:  result = i_imm << 12;
            default: result = '0;
        endcase
    end

    // a nop retires nothing
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid && (i_op != OP_NOP);
        end
    end

    always_ff @(posedge aclk) begin
        o_rd   <= i_dst;
        o_data <= result;
    end

endmodule

`default_nettype wire

//--- src/dual_issue_pkg.sv
`default_nettype none

package dual_issue_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // encodings match the hex opcode field of the vector file
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_SLL  = 4'h6,
        OP_SRL  = 4'h7,
        // signed compare, result 1 or 0
        OP_SLT  = 4'h8,
        OP_ADDI = 4'h9,
        OP_LUI  = 4'ha
    } opcode_e;

    // held pair status in the issue stage
    typedef enum logic [1:0] {
        ISSUE_EMPTY  = 2'd0,
        ISSUE_PAIR   = 2'd1,
        ISSUE_SECOND = 2'd2
    } issue_state_e;

endpackage

`default_nettype wire
